// File: stretch_defines.svh
`ifndef STRETCH_DEFINES_SVH
`define STRETCH_DEFINES_SVH

// Fraction bits of the vertical shrink factor
// The factor itself carries one extra whole bit above these
`define SCALE_FRACTION_BITS 6

// Width of an upstream or downstream row number
`define ROW_BITS 11

// Width of a column number inside one scanline
`define COLUMN_BITS 4

// Pixels per scanline, fetched and emitted as a whole row
`define ROW_PIXELS (1 << `COLUMN_BITS)

`endif

// File: stretchPkg.sv
`include "stretch_defines.svh"

package stretchPkg;

    // RGB 5-6-5 pixel with red in the top bits
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } pixel565;

    typedef logic [`ROW_BITS-1:0] rowIndex;
    typedef logic [`COLUMN_BITS-1:0] columnIndex;

    // One whole bit over SCALE_FRACTION_BITS fraction bits, so 1.0 is 7'b1000000
    typedef logic [`SCALE_FRACTION_BITS:0] shrinkFactor;

    // A scanline request, used both downstream and upstream
    typedef struct packed {
        rowIndex row;
    } rowRequest;

    typedef pixel565 upstreamPixel;

    // Write port of a line cache
    typedef struct packed {
        columnIndex column;
        pixel565 pixel;
    } cacheWrite;

    // Row held by a line cache; valid stays low until the first tag load
    typedef struct packed {
        rowIndex row;
        logic valid;
    } cacheTag;

    // One read-out job, issued per column
    typedef struct packed {
        logic upperInA;
        logic [`SCALE_FRACTION_BITS-1:0] fraction;
        columnIndex column;
        logic last;
    } blendJob;

    typedef struct packed {
        pixel565 pixel;
        columnIndex column;
        logic last;
    } outputPixel;

endpackage

// File: lineCache.sv
`include "stretch_defines.svh"

module lineCache (
    input  logic                   scalerClock,
    input  logic                   reset,
    input  logic                   tagLoad,
    input  stretchPkg::rowIndex    tagRow,
    input  logic                   writeEnable,
    input  stretchPkg::cacheWrite  write,
    input  stretchPkg::columnIndex readColumn,
    output stretchPkg::pixel565    readPixel,
    output stretchPkg::cacheTag    tag
);

    // One full upstream scanline
    stretchPkg::pixel565 rowMemory [`ROW_PIXELS];

    // Write port and registered read port share the clock
    // A read of a column written in the same cycle returns the old pixel
    always_ff @(posedge scalerClock) begin
        if (writeEnable) begin
            rowMemory[write.column] <= write.pixel;
        end
        readPixel <= rowMemory[readColumn];
    end

    // The tag names the row that the next fetch fills
    // Pixel data is left alone here because the fetch overwrites every column
    always_ff @(posedge scalerClock or posedge reset) begin
        if (reset) begin
            tag.row   <= '0;
            tag.valid <= 1'b0;
        end else if (tagLoad) begin
            tag.row   <= tagRow;
            tag.valid <= 1'b1;
        end
    end

endmodule

// File: cacheController.sv
`include "stretch_defines.svh"

module cacheController (
    input  logic                   scalerClock,
    input  logic                   reset,
    input  stretchPkg::shrinkFactor vShrinkFactor,
    input  logic                   downstreamRequestValid,
    input  stretchPkg::rowRequest  downstreamRequest,
    input  logic                   upstreamPixelValid,
    input  stretchPkg::cacheTag    tagA,
    input  stretchPkg::cacheTag    tagB,
    output logic                   upstreamRequestValid,
    output stretchPkg::rowRequest  upstreamRequest,
    output logic                   tagLoadA,
    output logic                   tagLoadB,
    output stretchPkg::rowIndex    tagRow,
    output logic                   writeEnableA,
    output logic                   writeEnableB,
    output stretchPkg::columnIndex writeColumn,
    output stretchPkg::columnIndex readColumn,
    output logic                   blendJobValid,
    output stretchPkg::blendJob    blendJob,
    output logic                   busy
);

    localparam int FRAC_BITS = `SCALE_FRACTION_BITS;
    localparam int COORD_BITS = `ROW_BITS + `SCALE_FRACTION_BITS;

    typedef enum logic [1:0] {stateIdle, stateMap, stateFetch, stateEmit} controlState;

    controlState state;
    logic drainPending;
    logic secondPending;
    logic olderIsB;
    stretchPkg::columnIndex fetchColumn;
    stretchPkg::columnIndex emitColumn;

    stretchPkg::rowIndex upperRow;
    stretchPkg::rowIndex lowerRow;
    logic [FRAC_BITS-1:0] fraction;
    logic upperInCacheA;
    logic fetchIntoB;

    logic [COORD_BITS-1:0] scaledRow;
    logic [COORD_BITS-1:0] halfStep;
    logic [COORD_BITS-1:0] centerOffset;
    logic [COORD_BITS-1:0] mappedCoord;
    stretchPkg::rowIndex mappedUpper;
    stretchPkg::rowIndex mappedLower;
    logic [FRAC_BITS-1:0] mappedFraction;

    logic accept;
    logic hitUpperA, hitUpperB, hitLowerA, hitLowerB;
    logic upperHit, lowerHit, needFetch, bothMiss;
    logic olderHoldsNeeded, mapLoadIntoB;
    logic fetchDone, startFetch, fetchB;
    stretchPkg::rowIndex fetchRow;

    // Upstream coordinate is row * factor plus half a factor step
    // A factor of 1.0 or more also moves back by half an upstream row to stay centered
    assign scaledRow = downstreamRequest.row * vShrinkFactor;
    assign halfStep = {`ROW_BITS'(0), vShrinkFactor[FRAC_BITS:1]};
    assign centerOffset = {`ROW_BITS'(0), vShrinkFactor[FRAC_BITS], (FRAC_BITS-1)'(0)};
    assign mappedCoord = scaledRow + halfStep - centerOffset;
    assign mappedUpper = mappedCoord[COORD_BITS-1:FRAC_BITS];
    assign mappedFraction = mappedCoord[FRAC_BITS-1:0];
    // With no fraction only the upper row contributes
    assign mappedLower = (mappedFraction == '0) ? mappedUpper : mappedUpper + `ROW_BITS'(1);

    assign accept = (state == stateIdle) && !busy && downstreamRequestValid;

    // Tag lookup on the registered rows during the map cycle
    assign hitUpperA = tagA.valid && (tagA.row == upperRow);
    assign hitUpperB = tagB.valid && (tagB.row == upperRow);
    assign hitLowerA = tagA.valid && (tagA.row == lowerRow);
    assign hitLowerB = tagB.valid && (tagB.row == lowerRow);
    assign upperHit = hitUpperA || hitUpperB;
    assign lowerHit = hitLowerA || hitLowerB;
    assign needFetch = !(upperHit && lowerHit);
    assign bothMiss = !upperHit && !lowerHit && (upperRow != lowerRow);

    // Replace the older cache unless it holds the other needed row
    assign olderHoldsNeeded = olderIsB ? (hitUpperB || hitLowerB) : (hitUpperA || hitLowerA);
    assign mapLoadIntoB = olderIsB ^ olderHoldsNeeded;

    // The second fetch of a double miss goes right after the last pixel of the first
    assign fetchDone = (state == stateFetch) && upstreamPixelValid && (fetchColumn == '1);
    assign startFetch = ((state == stateMap) && needFetch) || (fetchDone && secondPending);
    assign fetchRow = (state == stateMap) ? (upperHit ? lowerRow : upperRow) : lowerRow;
    assign fetchB = (state == stateMap) ? mapLoadIntoB : olderIsB;

    // Upstream data lands in the cache picked when its fetch started
    assign writeEnableA = (state == stateFetch) && upstreamPixelValid && !fetchIntoB;
    assign writeEnableB = (state == stateFetch) && upstreamPixelValid && fetchIntoB;
    assign writeColumn = fetchColumn;

    // One job per cycle while emitting, read address shared by both caches
    assign readColumn = emitColumn;
    assign blendJobValid = (state == stateEmit);
    assign blendJob = '{upperInA: upperInCacheA, fraction: fraction,
                        column: emitColumn, last: (emitColumn == '1)};

    always_ff @(posedge scalerClock or posedge reset) begin
        if (reset) begin
            state                <= stateIdle;
            busy                 <= 1'b0;
            drainPending         <= 1'b0;
            secondPending        <= 1'b0;
            olderIsB             <= 1'b0;
            fetchColumn          <= '0;
            emitColumn           <= '0;
            upstreamRequestValid <= 1'b0;
            tagLoadA             <= 1'b0;
            tagLoadB             <= 1'b0;
        end else begin
            upstreamRequestValid <= startFetch;
            tagLoadA <= startFetch && !fetchB;
            tagLoadB <= startFetch && fetchB;
            // The cache just loaded becomes the newer one
            if (startFetch) begin
                olderIsB <= !fetchB;
            end
            drainPending <= 1'b0;
            case (state)
                stateIdle: begin
                    // Last job still in the blender, busy drops as its pixel leaves
                    if (drainPending) begin
                        busy <= 1'b0;
                    end
                    if (accept) begin
                        busy  <= 1'b1;
                        state <= stateMap;
                    end
                end
                stateMap: begin
                    secondPending <= bothMiss;
                    fetchColumn   <= '0;
                    emitColumn    <= '0;
                    state         <= needFetch ? stateFetch : stateEmit;
                end
                stateFetch: begin
                    if (upstreamPixelValid) begin
                        fetchColumn <= fetchColumn + 1'b1;
                    end
                    if (fetchDone) begin
                        if (secondPending) begin
                            secondPending <= 1'b0;
                        end else begin
                            state <= stateEmit;
                        end
                    end
                end
                stateEmit: begin
                    emitColumn <= emitColumn + 1'b1;
                    if (emitColumn == '1) begin
                        drainPending <= 1'b1;
                        state        <= stateIdle;
                    end
                end
                default: state <= stateIdle;
            endcase
        end
    end

    // Mapped rows and fetch details are only looked at in the states that set them up
    always_ff @(posedge scalerClock) begin
        if (accept) begin
            upperRow <= mappedUpper;
            lowerRow <= mappedLower;
            fraction <= mappedFraction;
        end
        if (state == stateMap) begin
            // A missing upper row is always the first one fetched
            upperInCacheA <= upperHit ? hitUpperA : !mapLoadIntoB;
        end
        if (startFetch) begin
            upstreamRequest.row <= fetchRow;
            tagRow              <= fetchRow;
            fetchIntoB          <= fetchB;
        end
    end

endmodule

// File: pixelBlender.sv
`include "stretch_defines.svh"

module pixelBlender (
    input  logic                   scalerClock,
    input  logic                   reset,
    input  logic                   blendJobValid,
    input  stretchPkg::blendJob    blendJob,
    input  stretchPkg::pixel565    pixelA,
    input  stretchPkg::pixel565    pixelB,
    output logic                   outputValid,
    output stretchPkg::outputPixel outputPixel
);

    localparam int FRAC_BITS = `SCALE_FRACTION_BITS;

    logic stagedValid;
    stretchPkg::blendJob stagedJob;
    stretchPkg::pixel565 upperPixel;
    stretchPkg::pixel565 lowerPixel;
    stretchPkg::pixel565 blendedPixel;
    logic [FRAC_BITS-1:0] upperCoeff;

    // Weighted sum of one channel, red and blue are zero-extended to six bits
    function automatic logic [FRAC_BITS-1:0] blendChannel(
        input logic [FRAC_BITS-1:0] upperValue,
        input logic [FRAC_BITS-1:0] lowerValue,
        input logic [FRAC_BITS-1:0] upperWeight,
        input logic [FRAC_BITS-1:0] lowerWeight
    );
        logic [2*FRAC_BITS-1:0] weighted;
        weighted = upperValue * upperWeight + lowerValue * lowerWeight;
        return weighted[2*FRAC_BITS-1:FRAC_BITS];
    endfunction

    // Cache data shows up one cycle after the job, so the job waits here one stage
    assign upperPixel = stagedJob.upperInA ? pixelA : pixelB;
    assign lowerPixel = stagedJob.upperInA ? pixelB : pixelA;
    // Upper weight is 63 minus the fraction
    assign upperCoeff = ~stagedJob.fraction;

    assign blendedPixel.red = 5'(blendChannel({1'b0, upperPixel.red}, {1'b0, lowerPixel.red},
                                              upperCoeff, stagedJob.fraction));
    assign blendedPixel.green = blendChannel(upperPixel.green, lowerPixel.green,
                                             upperCoeff, stagedJob.fraction);
    assign blendedPixel.blue = 5'(blendChannel({1'b0, upperPixel.blue}, {1'b0, lowerPixel.blue},
                                               upperCoeff, stagedJob.fraction));

    always_ff @(posedge scalerClock or posedge reset) begin
        if (reset) begin
            stagedValid <= 1'b0;
            outputValid <= 1'b0;
        end else begin
            stagedValid <= blendJobValid;
            outputValid <= stagedValid;
        end
    end

    always_ff @(posedge scalerClock) begin
        stagedJob <= blendJob;
        // Zero fraction means the upstream row lines up exactly, pass it through
        outputPixel.pixel  <= (stagedJob.fraction == '0) ? upperPixel : blendedPixel;
        outputPixel.column <= stagedJob.column;
        outputPixel.last   <= stagedJob.last;
    end

endmodule

// File: verticalStretch.sv
module verticalStretch (
    input  logic                    scalerClock,
    input  logic                    reset,
    input  stretchPkg::shrinkFactor vShrinkFactor,
    input  logic                    downstreamRequestValid,
    input  stretchPkg::rowRequest   downstreamRequest,
    output logic                    busy,
    output logic                    upstreamRequestValid,
    output stretchPkg::rowRequest   upstreamRequest,
    input  logic                    upstreamPixelValid,
    input  stretchPkg::upstreamPixel upstreamPixelData,
    output logic                    outputValid,
    output stretchPkg::outputPixel  outputPixel
);

    stretchPkg::cacheTag tagA;
    stretchPkg::cacheTag tagB;
    logic tagLoadA;
    logic tagLoadB;
    stretchPkg::rowIndex tagRow;
    logic writeEnableA;
    logic writeEnableB;
    stretchPkg::columnIndex writeColumn;
    stretchPkg::columnIndex readColumn;
    stretchPkg::cacheWrite pixelWrite;
    stretchPkg::pixel565 pixelA;
    stretchPkg::pixel565 pixelB;
    logic blendJobValid;
    stretchPkg::blendJob blendJob;

    // Both caches see the same upstream pixel, the enables pick the target
    assign pixelWrite = '{column: writeColumn, pixel: upstreamPixelData};

    cacheController controller (
        .scalerClock, .reset, .vShrinkFactor,
        .downstreamRequestValid, .downstreamRequest,
        .upstreamPixelValid, .tagA, .tagB,
        .upstreamRequestValid, .upstreamRequest,
        .tagLoadA, .tagLoadB, .tagRow,
        .writeEnableA, .writeEnableB, .writeColumn,
        .readColumn, .blendJobValid, .blendJob, .busy
    );

    lineCache cacheA (
        .scalerClock, .reset, .tagLoad(tagLoadA), .tagRow,
        .writeEnable(writeEnableA), .write(pixelWrite),
        .readColumn, .readPixel(pixelA), .tag(tagA)
    );

    lineCache cacheB (
        .scalerClock, .reset, .tagLoad(tagLoadB), .tagRow,
        .writeEnable(writeEnableB), .write(pixelWrite),
        .readColumn, .readPixel(pixelB), .tag(tagB)
    );

    pixelBlender blender (
        .scalerClock, .reset, .blendJobValid, .blendJob,
        .pixelA, .pixelB, .outputValid, .outputPixel
    );

endmodule

// File: verticalStretch_sva.sv
module verticalStretch_sva (
    input logic                   scalerClock,
    input logic                   reset,
    input logic                   busy,
    input logic                   upstreamRequestValid,
    input logic                   outputValid,
    input stretchPkg::outputPixel outputPixel
);

    // Number of failed assertions so far, read by the testbench
    int assertionFailures = 0;

    // Fetch and output strobes sit inside the busy window
    // The final pixel leaves on the cycle busy falls
    strobeWhileBusy: assert property (@(posedge scalerClock) disable iff (reset)
        (upstreamRequestValid || (outputValid && !outputPixel.last)) |-> busy)
        else begin
            $error("strobe seen while busy is low");
            assertionFailures++;
        end

    // Output columns run back to back until the last pixel
    columnStep: assert property (@(posedge scalerClock) disable iff (reset)
        (outputValid && !outputPixel.last) |=>
            (outputValid && outputPixel.column == $past(outputPixel.column) + 4'd1))
        else begin
            $error("output column did not advance by one");
            assertionFailures++;
        end

    quietInReset: assert property (@(posedge scalerClock)
        reset |-> (!outputValid && !upstreamRequestValid && !busy))
        else begin
            $error("strobe or busy seen during reset");
            assertionFailures++;
        end

endmodule

bind verticalStretch verticalStretch_sva portChecks (
    .scalerClock(scalerClock),
    .reset(reset),
    .busy(busy),
    .upstreamRequestValid(upstreamRequestValid),
    .outputValid(outputValid),
    .outputPixel(outputPixel)
);

// File: tbVerticalStretch.sv
`include "stretch_defines.svh"

module tbVerticalStretch;

    localparam int IMAGE_ROWS = 64;
    localparam int RESET_CYCLES = 16;

    logic scalerClock;
    logic reset;
    stretchPkg::shrinkFactor vShrinkFactor;
    logic downstreamRequestValid;
    stretchPkg::rowRequest downstreamRequest;
    logic busy;
    logic upstreamRequestValid;
    stretchPkg::rowRequest upstreamRequest;
    logic upstreamPixelValid;
    stretchPkg::upstreamPixel upstreamPixelData;
    logic outputValid;
    stretchPkg::outputPixel outputPixel;

    // Upstream frame that the fetch model serves rows from
    stretchPkg::pixel565 image [IMAGE_ROWS][`ROW_PIXELS];

    // Golden file columns with one entry per test
    string testNames[$];
    int testFactors[$];
    int testRows[$];
    int testUppers[$];
    int testLowers[$];
    int testFetches[$];

    // Gaps before each upstream pixel, drawn up front from the seeded generator
    int gapTable[$];
    stretchPkg::rowRequest fetchedRows[$];
    stretchPkg::rowRequest expectedFetches[$];

    // Reference model of the two cache tags and the older pointer
    int cacheRow[2];
    bit cacheValid[2];
    int olderCache;

    int errorCount;
    int passedTests;
    int failedTests;
    bit testsLoaded;

    verticalStretch dut_i (
        .scalerClock(scalerClock),
        .reset(reset),
        .vShrinkFactor(vShrinkFactor),
        .downstreamRequestValid(downstreamRequestValid),
        .downstreamRequest(downstreamRequest),
        .busy(busy),
        .upstreamRequestValid(upstreamRequestValid),
        .upstreamRequest(upstreamRequest),
        .upstreamPixelValid(upstreamPixelValid),
        .upstreamPixelData(upstreamPixelData),
        .outputValid(outputValid),
        .outputPixel(outputPixel)
    );

    initial begin
        scalerClock = 1'b0;
        forever #5 scalerClock = ~scalerClock;
    end

    function automatic stretchPkg::pixel565 blendReference(
        input stretchPkg::pixel565 upper,
        input stretchPkg::pixel565 lower,
        input int fraction
    );
        stretchPkg::pixel565 result;
        int upperWeight;
        upperWeight = 63 - fraction;
        // An exact row hit keeps the upper pixel as it is
        if (fraction == 0) begin
            return upper;
        end
        result.red = 5'((int'(upper.red) * upperWeight + int'(lower.red) * fraction) >> 6);
        result.green = 6'((int'(upper.green) * upperWeight + int'(lower.green) * fraction) >> 6);
        result.blue = 5'((int'(upper.blue) * upperWeight + int'(lower.blue) * fraction) >> 6);
        return result;
    endfunction

    task automatic verifyPixel(input string name, input stretchPkg::outputPixel expected,
                               input stretchPkg::outputPixel actual);
        if (actual !== expected) begin
            $display("Error %s pixel column %0d expected %h actual %h",
                     name, expected.column, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkFetchedRow(input string name, input stretchPkg::rowRequest expected,
                                   input stretchPkg::rowRequest actual);
        if (actual !== expected) begin
            $display("Error %s fetched row expected %0d actual %0d", name, expected.row, actual.row);
            errorCount++;
        end
    endtask

    task automatic compareFetchCount(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("Error %s fetch count expected %0d actual %0d", name, expected, actual);
            errorCount++;
        end
    endtask

    // Applies the replacement rule to the tag model and lists the rows that must be fetched
    task automatic predictFetches(input int upper, input int lower);
        int needed[$];
        int victim;
        bit found;
        stretchPkg::rowRequest request;
        needed.push_back(upper);
        if (lower != upper) begin
            needed.push_back(lower);
        end
        foreach (needed[i]) begin
            found = (cacheValid[0] && cacheRow[0] == needed[i]) ||
                    (cacheValid[1] && cacheRow[1] == needed[i]);
            if (!found) begin
                victim = olderCache;
                // The older cache is spared when it holds the other needed row
                if (needed.size() == 2 && cacheValid[victim] && cacheRow[victim] == needed[1 - i]) begin
                    victim = 1 - victim;
                end
                cacheRow[victim] = needed[i];
                cacheValid[victim] = 1'b1;
                olderCache = 1 - victim;
                request.row = stretchPkg::rowIndex'(needed[i]);
                expectedFetches.push_back(request);
            end
        end
    endtask

    task automatic loadGolden();
        int fd;
        int fields;
        int factor, row, upper, lower, fetches;
        string textLine;
        string name;
        fd = $fopen("stretch_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file stretch_golden.txt");
            errorCount++;
            return;
        end
        while (!$feof(fd)) begin
            textLine = "";
            if ($fgets(textLine, fd) == 0) begin
                break;
            end
            // Comment and blank lines carry no test
            if (textLine.len() < 2 || textLine[0] == "#") begin
                continue;
            end
            fields = $sscanf(textLine, "%s %d %d %d %d %d", name, factor, row, upper, lower,
                             fetches);
            if (fields != 6) begin
                $display("Golden line could not be parsed: %s", textLine);
                errorCount++;
                continue;
            end
            testNames.push_back(name);
            testFactors.push_back(factor);
            testRows.push_back(row);
            testUppers.push_back(upper);
            testLowers.push_back(lower);
            testFetches.push_back(fetches);
        end
        $fclose(fd);
    endtask

    task automatic serveUpstreamRow(input stretchPkg::rowIndex row);
        int gap;
        for (int column = 0; column < `ROW_PIXELS; column++) begin
            gap = (gapTable.size() > 0) ? gapTable.pop_front() : 0;
            repeat (gap) @(negedge scalerClock);
            upstreamPixelValid = 1'b1;
            upstreamPixelData = image[row % IMAGE_ROWS][column];
            @(negedge scalerClock);
            upstreamPixelValid = 1'b0;
        end
    endtask

    // Upstream source answers each fetch strobe with its row, in column order
    initial begin : upstreamModel
        stretchPkg::rowRequest request;
        upstreamPixelValid = 1'b0;
        upstreamPixelData = '0;
        forever begin
            @(negedge scalerClock);
            // A second fetch can follow right after the last pixel of the first
            while (upstreamRequestValid && !reset) begin
                request = upstreamRequest;
                fetchedRows.push_back(request);
                serveUpstreamRow(request.row);
            end
        end
    end

    task automatic runTest(input int index);
        stretchPkg::outputPixel expected;
        int coord, fraction, errorsBefore, upper, lower;
        string name;
        name = testNames[index];
        upper = testUppers[index];
        lower = testLowers[index];
        errorsBefore = errorCount;
        // Downstream row times factor plus half a step, minus half a row for factors of 1.0 and up
        coord = testRows[index] * testFactors[index] + testFactors[index] / 2 -
                ((testFactors[index] >= 64) ? 32 : 0);
        fraction = coord % 64;
        if (coord / 64 != upper || ((fraction == 0) ? upper : upper + 1) != lower) begin
            $display("Golden entry %s disagrees with the row mapping rule", name);
            errorCount++;
        end
        expectedFetches.delete();
        fetchedRows.delete();
        predictFetches(upper, lower);
        if (expectedFetches.size() != testFetches[index]) begin
            $display("Golden entry %s disagrees with the cache replacement rule", name);
            errorCount++;
        end
        @(negedge scalerClock);
        while (busy) @(negedge scalerClock);
        vShrinkFactor = stretchPkg::shrinkFactor'(testFactors[index]);
        downstreamRequest.row = stretchPkg::rowIndex'(testRows[index]);
        downstreamRequestValid = 1'b1;
        @(negedge scalerClock);
        downstreamRequestValid = 1'b0;
        for (int column = 0; column < `ROW_PIXELS; column++) begin
            while (!outputValid) @(negedge scalerClock);
            expected.pixel = blendReference(image[upper % IMAGE_ROWS][column],
                                            image[lower % IMAGE_ROWS][column], fraction);
            expected.column = stretchPkg::columnIndex'(column);
            expected.last = (column == `ROW_PIXELS - 1);
            verifyPixel(name, expected, outputPixel);
            @(negedge scalerClock);
        end
        compareFetchCount(name, testFetches[index], fetchedRows.size());
        for (int k = 0; k < fetchedRows.size() && k < expectedFetches.size(); k++) begin
            checkFetchedRow(name, expectedFetches[k], fetchedRows[k]);
        end
        if (errorCount == errorsBefore) begin
            $display("Test %s ok", name);
            passedTests++;
        end else begin
            $display("Test %s failed with %0d errors", name, errorCount - errorsBefore);
            failedTests++;
        end
    endtask

    initial begin : mainSequence
        int totalErrors;
        reset = 1'b1;
        vShrinkFactor = '0;
        downstreamRequestValid = 1'b0;
        downstreamRequest = '0;
        errorCount = 0;
        passedTests = 0;
        failedTests = 0;
        cacheValid[0] = 1'b0;
        cacheValid[1] = 1'b0;
        olderCache = 0;
        void'($urandom(40874));
        for (int r = 0; r < IMAGE_ROWS; r++) begin
            for (int c = 0; c < `ROW_PIXELS; c++) begin
                image[r][c] = 16'($urandom());
            end
        end
        loadGolden();
        if (testNames.size() == 0) begin
            $display("The golden file holds no tests");
            errorCount++;
        end
        repeat (2 * `ROW_PIXELS * testNames.size()) gapTable.push_back($urandom_range(3, 0));
        testsLoaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge scalerClock);
        @(negedge scalerClock);
        reset = 1'b0;
        foreach (testNames[i]) begin
            runTest(i);
        end
        totalErrors = errorCount + dut_i.portChecks.assertionFailures;
        $display("%0d tests, %0d passed, %0d failed, %0d errors, %0d assertion failures",
                 testNames.size(), passedTests, failedTests, errorCount,
                 dut_i.portChecks.assertionFailures);
        if (totalErrors == 0 && failedTests == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Each test gets two slow row fetches plus read-out and some slack
    initial begin : watchdog
        int timeoutCycles;
        wait (testsLoaded);
        timeoutCycles = RESET_CYCLES + testNames.size() * (2 * `ROW_PIXELS * 4 + 20);
        #(timeoutCycles * 10);
        $display("Watchdog expired after %0d cycles because the DUT stopped responding",
                 timeoutCycles);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: stretch_golden.txt
# Vertical stretch tests, one per line
# name  factor(1/64 units)  downstreamRow  upperRow  lowerRow  fetches
identityCold 64 5 5 5 1
halfOddCold 32 21 10 11 2
halfBothCached 32 20 10 11 0
halfOneNew 32 23 11 12 1
identityCachedB 64 12 12 12 0
threeQuarterMiss 48 7 5 6 2
oneHalfKeepLower 96 3 4 5 1
quarterTop 16 0 0 1 2
fiveQuarterMiss 80 2 2 3 2
identityLastRow 64 63 63 63 1
nearTwoExact 127 31 62 62 1
halfBothHit 32 125 62 63 0

// File: build.f
+incdir+.
stretchPkg.sv
lineCache.sv
cacheController.sv
pixelBlender.sv
verticalStretch.sv
verticalStretch_sva.sv
tbVerticalStretch.sv

// File: Bender.yml
package:
  name: vertical_stretch

sources:
  - include_dirs:
      - .
    files:
      - stretchPkg.sv
      - lineCache.sv
      - cacheController.sv
      - pixelBlender.sv
      - verticalStretch.sv
      - target: test
        files:
          - verticalStretch_sva.sv
          - tbVerticalStretch.sv
